// File: sim.f
+incdir+include
logic/ctrlPkg.sv
logic/instrDecoder.sv
logic/controlSequencer.sv
logic/controlEncoder.sv
logic/ctrlUnit.sv
testbench/ctrlUnit_properties.sv
testbench/ctrlUnitChecker.sv
testbench/ctrlUnitTb.sv

// File: testbench/ctrlUnitTb.sv
`include "ctrlUnit_config.svh"

module ctrlUnitTb;

    localparam int NumTests = 7; // Instruction tests after the reset test
    localparam int InstrsPerTest = 4;
    localparam int TimeoutCycles = NumTests * InstrsPerTest * 9 + 20;

    logic clk = 1'b0;
    logic reset;
    ctrlPkg::opcodeT opcode;
    ctrlPkg::functT funct;
    logic pcWrite;
    logic irWrite;
    logic abWrite;
    logic regWrite;
    logic aluOutWrite;
    logic cpuReset;
    ctrlPkg::regDstT regDst;
    ctrlPkg::srcSelT aluSrcA;
    ctrlPkg::srcSelT aluSrcB;
    ctrlPkg::aluOpT aluCtrl;
    int testIdx;
    logic runDone;
    int testsPassed;
    int testsFailed;
    int mismatches;
    logic reportDone;
    logic [7:0] lfsr = 8'd76;

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsrNext(logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic takeBits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            value = (value << 1) | lfsr[0];
        end
    endtask

    // Called on the edge that starts fetch step 0
    task automatic runInstr(input int kind);
        ctrlPkg::opcodeT op;
        ctrlPkg::functT fn;
        int fill;
        takeBits(6, fill);
        op = `OP_RTYPE;
        fn = ctrlPkg::functT'(fill); // Don't care outside R-type
        case (kind)
            0: fn = `FN_ADD;
            1: fn = `FN_AND;
            2: fn = `FN_SUB;
            3: op = `OP_ADDI;
            4: fn = 6'd39; // NOR, not implemented
            5: op = 6'd4;
            default: op = `OP_HALT;
        endcase
        opcode <= op;
        funct <= fn;
        repeat ((kind < 4) ? 9 : 6) @(posedge clk);
    endtask

    ctrlUnit dut_i (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .funct       (funct),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .abWrite     (abWrite),
        .regWrite    (regWrite),
        .aluOutWrite (aluOutWrite),
        .regDst      (regDst),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluCtrl     (aluCtrl),
        .cpuReset    (cpuReset)
    );

    ctrlUnitChecker checker_i (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .funct       (funct),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .abWrite     (abWrite),
        .regWrite    (regWrite),
        .aluOutWrite (aluOutWrite),
        .cpuReset    (cpuReset),
        .regDst      (regDst),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluCtrl     (aluCtrl),
        .testIdx     (testIdx),
        .runDone     (runDone),
        .testsPassed (testsPassed),
        .testsFailed (testsFailed),
        .mismatches  (mismatches),
        .reportDone  (reportDone)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    initial begin
        int kind;
        int assertFails;
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        testIdx = 0;
        runDone = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (int t = 1; t <= NumTests; t++) begin
            testIdx <= t;
            if (t == NumTests) begin
                runInstr(6);
                repeat (5) @(posedge clk); // Parked in halt
                reset <= 1'b1;
                repeat (4) @(posedge clk);
                reset <= 1'b0;
                runInstr(0);
            end else begin
                runInstr(t - 1); // Named instruction first, then random picks
                for (int i = 1; i < InstrsPerTest; i++) begin
                    takeBits(3, kind);
                    runInstr(kind % 6);
                end
            end
        end
        runDone <= 1'b1;
        wait (reportDone);
        assertFails = dut_i.props_i.assertFails;
        $display("Tests: %0d passed, %0d failed, %0d mismatches, %0d assertion failures",
                 testsPassed, testsFailed, mismatches, assertFails);
        if (testsFailed == 0 && mismatches == 0 && assertFails == 0
                && testsPassed == NumTests + 1) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(TimeoutCycles * 20);
        $display("Run timed out after %0d cycles without finishing", TimeoutCycles);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: testbench/ctrlUnitChecker.sv
`include "ctrlUnit_config.svh"

module ctrlUnitChecker (
    input  logic            clk,
    input  logic            reset,
    input  ctrlPkg::opcodeT opcode,
    input  ctrlPkg::functT  funct,
    input  logic            pcWrite,
    input  logic            irWrite,
    input  logic            abWrite,
    input  logic            regWrite,
    input  logic            aluOutWrite,
    input  logic            cpuReset,
    input  ctrlPkg::regDstT regDst,
    input  ctrlPkg::srcSelT aluSrcA,
    input  ctrlPkg::srcSelT aluSrcB,
    input  ctrlPkg::aluOpT  aluCtrl,
    input  int              testIdx,
    input  logic            runDone,
    output int              testsPassed,
    output int              testsFailed,
    output int              mismatches,
    output logic            reportDone
);

    ctrlPkg::phaseT mPhase;
    ctrlPkg::stepT mStep;
    ctrlPkg::aluOpT mOp;
    logic modelValid = 1'b0;
    int curTest = -1;
    int testErrors;
    int testCycles;
    logic [14:0] expWord; // {writes[5:0], regDst, aluSrcA, aluSrcB, aluCtrl}
    logic [14:0] actWord;

    function automatic string testName(int idx);
        case (idx)
            0: return "reset";
            1: return "add";
            2: return "and";
            3: return "sub";
            4: return "addi";
            5: return "badFunct";
            6: return "badOpcode";
            default: return "halt";
        endcase
    endfunction

    // {phase, ALU op} for an instruction at the end of fetch
    function automatic logic [4:0] decodeExpect(ctrlPkg::opcodeT op, ctrlPkg::functT fn);
        if (op == `OP_ADDI)
            return {ctrlPkg::PhaseExecImm, `ALU_ADD};
        if (op == `OP_HALT)
            return {ctrlPkg::PhaseHalt, `ALU_NONE};
        if (op != `OP_RTYPE)
            return {ctrlPkg::PhaseFetch, `ALU_NONE};
        case (fn)
            `FN_ADD: return {ctrlPkg::PhaseExecR, `ALU_ADD};
            `FN_AND: return {ctrlPkg::PhaseExecR, `ALU_AND};
            `FN_SUB: return {ctrlPkg::PhaseExecR, `ALU_SUB};
            default: return {ctrlPkg::PhaseFetch, `ALU_NONE};
        endcase
    endfunction

    function automatic logic [14:0] refControl(ctrlPkg::phaseT ph, ctrlPkg::stepT st,
                                               ctrlPkg::aluOpT op);
        logic [5:0] writes; // pc, ir, ab, reg, aluOut, cpuReset
        logic [1:0] dst;
        logic [1:0] srcA;
        logic [1:0] srcB;
        logic [2:0] alu;
        writes = '0;
        dst = `DST_RT;
        srcA = `SRC_A_PC;
        srcB = `SRC_B_REG;
        alu = `ALU_NONE;
        if (ph == ctrlPkg::PhaseFetch) begin
            if (st <= 3) begin
                alu = `ALU_ADD; // PC + 4
                srcB = `SRC_B_FOUR;
            end
            if (st == 3)
                writes = 6'b110010;
            if (st == 4)
                writes = 6'b001000;
        end else if (ph == ctrlPkg::PhaseExecR) begin
            alu = op;
            srcA = `SRC_A_REG;
            writes = {3'b000, st == 1, st == 0, 1'b0};
            dst = (st >= 1) ? `DST_RD : `DST_RT;
        end else if (ph == ctrlPkg::PhaseExecImm) begin
            alu = `ALU_ADD;
            srcA = `SRC_A_REG;
            srcB = `SRC_B_IMM;
            writes = {3'b000, st == 1, 2'b10};
        end else begin
            writes = 6'b000001;
        end
        return {writes, dst, srcA, srcB, alu};
    endfunction

    task automatic closeTest();
        if (testErrors == 0)
            testsPassed++;
        else
            testsFailed++;
        $display("Test %-10s %s after %0d cycles, %0d mismatches", testName(curTest),
                 (testErrors == 0) ? "passed" : "failed", testCycles, testErrors);
    endtask

    initial begin
        testsPassed = 0;
        testsFailed = 0;
        mismatches = 0;
        reportDone = 1'b0;
    end

    // Reference model of phase and step
    always @(posedge clk) begin
        logic [4:0] dec;
        dec = decodeExpect(opcode, funct);
        if (reset) begin
            modelValid <= 1'b1;
            mPhase <= ctrlPkg::PhaseFetch;
            mStep <= '0;
            mOp <= `ALU_NONE;
        end else if (mPhase == ctrlPkg::PhaseFetch) begin
            mStep <= (mStep == `FETCH_STEPS - 1) ? '0 : mStep + 1'b1;
            if (mStep == `FETCH_STEPS - 1) begin
                mPhase <= ctrlPkg::phaseT'(dec[4:3]);
                mOp <= dec[2:0];
            end
        end else if (mPhase != ctrlPkg::PhaseHalt) begin
            mStep <= (mStep == `EXEC_STEPS - 1) ? '0 : mStep + 1'b1;
            if (mStep == `EXEC_STEPS - 1)
                mPhase <= ctrlPkg::PhaseFetch;
        end
    end

    // Outputs are settled mid cycle
    always @(negedge clk) begin
        if (modelValid && !reportDone) begin
            if (testIdx != curTest || runDone) begin
                if (curTest >= 0)
                    closeTest();
                curTest = testIdx;
                testErrors = 0;
                testCycles = 0;
            end
            if (runDone) begin
                reportDone = 1'b1;
            end else begin
                expWord = refControl(mPhase, mStep, mOp);
                actWord = {pcWrite, irWrite, abWrite, regWrite, aluOutWrite, cpuReset,
                           regDst, aluSrcA, aluSrcB, aluCtrl};
                testCycles++;
                if (actWord !== expWord) begin
                    testErrors++;
                    mismatches++;
                    $display("[FAIL] %s: expected %h actual %h (phase %s step %0d)",
                             testName(curTest), expWord, actWord, mPhase.name(), mStep);
                end
            end
        end
    end

endmodule

// File: testbench/ctrlUnit_properties.sv
module ctrlUnitProperties (
    input logic clk,
    input logic reset,
    input logic pcWrite,
    input logic irWrite,
    input logic regWrite,
    input logic cpuReset
);

    int assertFails = 0;

    pcIrTogether: assert property (@(posedge clk) disable iff (reset) pcWrite == irWrite)
        else begin
            assertFails++;
            $error("pcWrite and irWrite differ");
        end

    // Register file is written once per instruction
    singleRegWrite: assert property (@(posedge clk) disable iff (reset) regWrite |=> !regWrite)
        else begin
            assertFails++;
            $error("regWrite high in two consecutive cycles");
        end

    haltHeld: assert property (@(posedge clk) disable iff (reset) cpuReset |=> cpuReset)
        else begin
            assertFails++;
            $error("cpuReset dropped without reset");
        end

endmodule

bind ctrlUnit ctrlUnitProperties props_i (
    .clk      (clk),
    .reset    (reset),
    .pcWrite  (pcWrite),
    .irWrite  (irWrite),
    .regWrite (regWrite),
    .cpuReset (cpuReset)
);

// File: logic/ctrlUnit.sv
module ctrlUnit (
    input  logic            clk,
    input  logic            reset,

    // Instruction fields, held for the whole instruction
    input  ctrlPkg::opcodeT opcode,
    input  ctrlPkg::functT  funct,

    // Datapath controls
    output logic            pcWrite,
    output logic            irWrite,
    output logic            abWrite,
    output logic            regWrite,
    output logic            aluOutWrite,
    output ctrlPkg::regDstT regDst,
    output ctrlPkg::srcSelT aluSrcA,
    output ctrlPkg::srcSelT aluSrcB,
    output ctrlPkg::aluOpT  aluCtrl,

    output logic            cpuReset
);

    ctrlPkg::phaseT nextPhase;
    ctrlPkg::aluOpT decodedOp;
    ctrlPkg::phaseT phase;
    ctrlPkg::stepT step;
    ctrlPkg::aluOpT aluOp; // Latched at end of fetch

    instrDecoder decoder_i (
        .opcode    (opcode),
        .funct     (funct),
        .nextPhase (nextPhase),
        .decodedOp (decodedOp)
    );

    controlSequencer sequencer_i (
        .clk       (clk),
        .reset     (reset),
        .nextPhase (nextPhase),
        .decodedOp (decodedOp),
        .phase     (phase),
        .step      (step),
        .aluOp     (aluOp)
    );

    controlEncoder encoder_i (
        .phase       (phase),
        .step        (step),
        .aluOp       (aluOp),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .abWrite     (abWrite),
        .regWrite    (regWrite),
        .aluOutWrite (aluOutWrite),
        .cpuReset    (cpuReset),
        .regDst      (regDst),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluCtrl     (aluCtrl)
    );

endmodule

// File: logic/controlEncoder.sv
`include "ctrlUnit_config.svh"

module controlEncoder (
    input  ctrlPkg::phaseT  phase,
    input  ctrlPkg::stepT   step,
    input  ctrlPkg::aluOpT  aluOp,
    output logic            pcWrite,
    output logic            irWrite,
    output logic            abWrite,
    output logic            regWrite,
    output logic            aluOutWrite,
    output logic            cpuReset,
    output ctrlPkg::regDstT regDst,
    output ctrlPkg::srcSelT aluSrcA,
    output ctrlPkg::srcSelT aluSrcB,
    output ctrlPkg::aluOpT  aluCtrl
);

    always_comb begin
        pcWrite = 1'b0;
        irWrite = 1'b0;
        abWrite = 1'b0;
        regWrite = 1'b0;
        aluOutWrite = 1'b0;
        cpuReset = 1'b0;
        regDst = `DST_RT;
        aluSrcA = `SRC_A_PC;
        aluSrcB = `SRC_B_REG;
        aluCtrl = `ALU_NONE;

        case (phase)
            ctrlPkg::PhaseFetch: begin
                case (step)
                    3'd0,
                    3'd1,
                    3'd2: begin
                        // PC + 4 on the ALU while memory settles
                        aluCtrl = `ALU_ADD;
                        aluSrcB = `SRC_B_FOUR;
                    end
                    3'd3: begin
                        aluCtrl = `ALU_ADD;
                        aluSrcB = `SRC_B_FOUR;
                        pcWrite = 1'b1;
                        irWrite = 1'b1;
                        aluOutWrite = 1'b1;
                    end
                    3'd4: begin
                        abWrite = 1'b1; // Register operands into A and B
                    end
                    default: begin
                        aluCtrl = `ALU_NONE; // Decode step, nothing driven
                    end
                endcase
            end

            ctrlPkg::PhaseExecR: begin
                aluCtrl = aluOp;
                aluSrcA = `SRC_A_REG;
                aluSrcB = `SRC_B_REG;
                case (step)
                    3'd0: begin
                        aluOutWrite = 1'b1;
                    end
                    3'd1: begin
                        regWrite = 1'b1;
                        regDst = `DST_RD;
                    end
                    3'd2: begin
                        regDst = `DST_RD;
                    end
                    default: begin
                        regDst = `DST_RT;
                    end
                endcase
            end

            ctrlPkg::PhaseExecImm: begin
                aluCtrl = `ALU_ADD;
                aluSrcA = `SRC_A_REG;
                aluSrcB = `SRC_B_IMM;
                regDst = `DST_RT; // Immediate form writes rt
                aluOutWrite = 1'b1;
                regWrite = (step == 3'd1);
            end

            ctrlPkg::PhaseHalt: begin
                cpuReset = 1'b1;
            end

            default: begin
                cpuReset = 1'b0;
            end
        endcase
    end

endmodule

// File: logic/controlSequencer.sv
`include "ctrlUnit_config.svh"

module controlSequencer (
    input  logic           clk,
    input  logic           reset,
    input  ctrlPkg::phaseT nextPhase,
    input  ctrlPkg::aluOpT decodedOp,
    output ctrlPkg::phaseT phase,
    output ctrlPkg::stepT  step,
    output ctrlPkg::aluOpT aluOp
);

    localparam ctrlPkg::stepT LastFetchStep = ctrlPkg::stepT'(`FETCH_STEPS - 1);
    localparam ctrlPkg::stepT LastExecStep = ctrlPkg::stepT'(`EXEC_STEPS - 1);

    ctrlPkg::phaseT phaseReg;
    ctrlPkg::stepT stepReg;
    ctrlPkg::aluOpT aluOpReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            phaseReg <= ctrlPkg::PhaseFetch;
            stepReg <= '0;
            aluOpReg <= `ALU_NONE;
        end else begin
            case (phaseReg)
                ctrlPkg::PhaseFetch: begin
                    if (stepReg == LastFetchStep) begin
                        // Decode result taken at the end of fetch
                        phaseReg <= nextPhase;
                        aluOpReg <= decodedOp;
                        stepReg <= '0;
                    end else begin
                        stepReg <= stepReg + 1'b1;
                    end
                end
                ctrlPkg::PhaseExecR,
                ctrlPkg::PhaseExecImm: begin
                    if (stepReg == LastExecStep) begin
                        phaseReg <= ctrlPkg::PhaseFetch;
                        stepReg <= '0;
                    end else begin
                        stepReg <= stepReg + 1'b1;
                    end
                end
                ctrlPkg::PhaseHalt: begin
                    phaseReg <= ctrlPkg::PhaseHalt; // Parked until reset
                    stepReg <= '0;
                end
                default: begin
                    phaseReg <= ctrlPkg::PhaseFetch;
                    stepReg <= '0;
                end
            endcase
        end
    end

    assign phase = phaseReg;
    assign step = stepReg;
    assign aluOp = aluOpReg;

endmodule

// File: logic/instrDecoder.sv
`include "ctrlUnit_config.svh"

module instrDecoder (
    input  ctrlPkg::opcodeT opcode,
    input  ctrlPkg::functT  funct,
    output ctrlPkg::phaseT  nextPhase,
    output ctrlPkg::aluOpT  decodedOp
);

    always_comb begin
        // Unknown encodings fall back to fetch
        nextPhase = ctrlPkg::PhaseFetch;
        decodedOp = `ALU_NONE;

        case (opcode)
            `OP_RTYPE: begin
                case (funct)
                    `FN_ADD: begin
                        nextPhase = ctrlPkg::PhaseExecR;
                        decodedOp = `ALU_ADD;
                    end
                    `FN_AND: begin
                        nextPhase = ctrlPkg::PhaseExecR;
                        decodedOp = `ALU_AND;
                    end
                    `FN_SUB: begin
                        nextPhase = ctrlPkg::PhaseExecR;
                        decodedOp = `ALU_SUB;
                    end
                    default: begin
                        nextPhase = ctrlPkg::PhaseFetch;
                        decodedOp = `ALU_NONE;
                    end
                endcase
            end
            `OP_ADDI: begin
                nextPhase = ctrlPkg::PhaseExecImm;
                decodedOp = `ALU_ADD;
            end
            `OP_HALT: begin
                nextPhase = ctrlPkg::PhaseHalt; // Only reset leaves this
            end
            default: begin
                nextPhase = ctrlPkg::PhaseFetch;
            end
        endcase
    end

endmodule

// File: logic/ctrlPkg.sv
`include "ctrlUnit_config.svh"

package ctrlPkg;

    typedef logic [`OPCODE_WIDTH-1:0] opcodeT;
    typedef logic [`FUNCT_WIDTH-1:0] functT;
    typedef logic [`ALU_OP_WIDTH-1:0] aluOpT;

    // ALU operand and register file selects
    typedef logic [`SEL_WIDTH-1:0] srcSelT;
    typedef logic [`SEL_WIDTH-1:0] regDstT;

    typedef logic [`STEP_WIDTH-1:0] stepT;

    // Top level phase of the multicycle sequence
    typedef enum logic [1:0] {
        PhaseFetch,
        PhaseExecR,
        PhaseExecImm,
        PhaseHalt
    } phaseT;

endpackage

// File: include/ctrlUnit_config.svh
`ifndef CTRL_UNIT_CONFIG_SVH
`define CTRL_UNIT_CONFIG_SVH

`define OPCODE_WIDTH 6
`define FUNCT_WIDTH 6
`define ALU_OP_WIDTH 3
`define SEL_WIDTH 2 // Mux select width
`define STEP_WIDTH 3

`define FETCH_STEPS 6
`define EXEC_STEPS 3

`define OP_RTYPE 6'd0
`define OP_ADDI 6'd8
`define OP_HALT 6'd63

`define FN_ADD 6'd32
`define FN_AND 6'd36
`define FN_SUB 6'd34

`define ALU_NONE 3'd0
`define ALU_ADD 3'd1
`define ALU_SUB 3'd2
`define ALU_AND 3'd3

`define SRC_A_PC 2'd0
`define SRC_A_REG 2'd1
`define SRC_B_REG 2'd0
`define SRC_B_FOUR 2'd1 // PC increment
`define SRC_B_IMM 2'd2
`define DST_RT 2'd0
`define DST_RD 2'd1

`endif
